//--- src/vrf_pkg.sv
`default_nettype none

package vrf_pkg;

  //////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////

  localparam int unsigned VLEN       = 128;
  localparam int unsigned PIPE_WIDTH = 32;
  localparam int unsigned CNT_W      = 8;

  // Elements per register at byte SEW and LMUL of one
  localparam logic [CNT_W-1:0] NUM_BYTE_OPS = CNT_W'((VLEN / PIPE_WIDTH) * 4);

  typedef logic [PIPE_WIDTH-1:0] word_t;

  //////////////////////////////////////////////////
  // Vector type encodings
  //////////////////////////////////////////////////

  typedef enum logic [2:0] {
    SEW_8  = 3'd0,
    SEW_16 = 3'd1,
    SEW_32 = 3'd2,
    SEW_64 = 3'd3
  } vsew_e;

  // Two's complement with negative values meaning fractional LMUL
  typedef enum logic [2:0] {
    LMUL_1    = 3'b000,
    LMUL_2    = 3'b001,
    LMUL_4    = 3'b010,
    LMUL_8    = 3'b011,
    LMUL_RSVD = 3'b100,
    LMUL_F8   = 3'b101,
    LMUL_F4   = 3'b110,
    LMUL_F2   = 3'b111
  } vlmul_e;

  typedef struct packed {
    vsew_e  sew;
    vlmul_e lmul;
  } vtype_t;

  // One enable per access of the operation
  typedef struct packed {
    logic rd_rs1;
    logic rd_rs2;
    logic wr_rd;
  } sel_op_t;

  //////////////////////////////////////////////////
  // Bus and address generator
  //////////////////////////////////////////////////

  typedef struct packed {
    logic  req;
    logic  we;
    word_t wdata;
  } mem_req_t;

  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    word_t rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic load;
    logic get_rs1;
    logic get_rs2;
    logic get_rd;
    logic incr;
  } agu_cmd_t;

endpackage

`default_nettype wire

//--- src/vrf_iter_counter.sv
`timescale 1ns/1ps
`default_nettype none

module vrf_iter_counter (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            load_i,
  input  logic            step_i,
  input  vrf_pkg::vtype_t vtype_i,
  output logic            last_o
);

  logic [vrf_pkg::CNT_W-1:0] count_q;
  logic [vrf_pkg::CNT_W-1:0] base_cnt;
  logic [vrf_pkg::CNT_W-1:0] init_cnt;
  logic [2:0]                lmul_raw;
  logic [2:0]                lmul_mag;

  // Element count from SEW, then scaled by LMUL
  always_comb begin
    lmul_raw = vtype_i.lmul;
    lmul_mag = 3'(~lmul_raw + 3'd1);
    base_cnt = vrf_pkg::NUM_BYTE_OPS >> vtype_i.sew;
    if (lmul_raw[2]) begin
      init_cnt = base_cnt >> lmul_mag;
    end else begin
      init_cnt = base_cnt << lmul_raw;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else if (load_i) begin
      count_q <= init_cnt;
    end else if (step_i) begin
      count_q <= count_q - 1'b1;
    end
  end

  assign last_o = (count_q == 'd1);

  a_no_load_and_step : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(load_i && step_i));

  a_no_step_at_zero : assert property (@(posedge clk_i) disable iff (!rst_ni)
    step_i |-> (count_q != '0));

endmodule

`default_nettype wire

//--- src/vrf_seq_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module vrf_seq_ctrl (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               req_i,
  input  vrf_pkg::sel_op_t   sel_op_i,
  input  vrf_pkg::word_t     wdata_i,
  input  logic               gnt_i,
  input  logic               last_i,
  output logic               load_o,
  output logic               step_o,
  output vrf_pkg::mem_req_t  mem_req_o,
  output vrf_pkg::agu_cmd_t  agu_o,
  output logic               vector_done_o
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_START,
    S_READ1,
    S_READ2,
    S_WRITE
  } state_e;

  state_e state_q;
  state_e state_d;

  logic first_rs1;
  logic issue_first;
  logic iter_end;

  // An iteration opens with rs1 if selected, else directly with rs2
  assign first_rs1 = sel_op_i.rd_rs1;

  //////////////////////////////////////////////////
  // State register
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////////////////////////
  // Next state and bus requests
  //////////////////////////////////////////////////

  always_comb begin
    state_d         = state_q;
    load_o          = 1'b0;
    step_o          = 1'b0;
    mem_req_o.req   = 1'b0;
    mem_req_o.we    = 1'b0;
    mem_req_o.wdata = wdata_i;
    agu_o           = '0;
    vector_done_o   = 1'b0;
    issue_first     = 1'b0;
    iter_end        = 1'b0;

    case (state_q)
      S_IDLE: begin
        if (req_i) begin
          agu_o.load = 1'b1;
          load_o     = 1'b1;
          state_d    = S_START;
        end
      end

      S_START: begin
        // Without a second read there is nothing legal to sequence
        if (sel_op_i.rd_rs2) begin
          issue_first = 1'b1;
        end else begin
          state_d = S_IDLE;
        end
      end

      // After the rs1 grant the rs2 read follows
      S_READ1: begin
        mem_req_o.req = 1'b1;
        agu_o.get_rs2 = 1'b1;
        if (gnt_i) begin
          agu_o.incr = 1'b1;
          state_d    = S_READ2;
        end
      end

      S_READ2: begin
        if (sel_op_i.wr_rd) begin
          mem_req_o.req = 1'b1;
          mem_req_o.we  = 1'b1;
          agu_o.get_rd  = 1'b1;
          if (gnt_i) begin
            agu_o.incr = 1'b1;
            state_d    = S_WRITE;
          end
        end else begin
          iter_end = 1'b1;
        end
      end

      S_WRITE: begin
        iter_end = 1'b1;
      end

      default: begin
        state_d = S_IDLE;
      end
    endcase

    // End of one iteration
    if (iter_end) begin
      if (last_i) begin
        vector_done_o = 1'b1;
        state_d       = S_IDLE;
      end else begin
        issue_first = 1'b1;
      end
    end

    // First read of an iteration is held until granted
    if (issue_first) begin
      mem_req_o.req = 1'b1;
      agu_o.get_rs1 = first_rs1;
      agu_o.get_rs2 = !first_rs1;
      if (gnt_i) begin
        agu_o.incr = 1'b1;
        step_o     = iter_end;
        state_d    = first_rs1 ? S_READ1 : S_READ2;
      end
    end
  end

  a_req_held : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_req_o.req && !gnt_i) |=> (mem_req_o.req && $stable(mem_req_o.we)));

endmodule

`default_nettype wire

//--- src/vrf_operand_regs.sv
`timescale 1ns/1ps
`default_nettype none

module vrf_operand_regs (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  vrf_pkg::mem_rsp_t  rsp_i,
  input  vrf_pkg::agu_cmd_t  agu_i,
  output vrf_pkg::word_t     rdata_a_o,
  output vrf_pkg::word_t     rdata_b_o
);

  logic rd_grant;
  logic pending_q;
  // Low for rs1, high for rs2
  logic target_q;

  assign rd_grant = rsp_i.gnt && (agu_i.get_rs1 || agu_i.get_rs2);

  //////////////////////////////////////////////////
  // Outstanding read tracking
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
      target_q  <= 1'b0;
    end else if (rd_grant) begin
      pending_q <= 1'b1;
      target_q  <= agu_i.get_rs2;
    end else if (rsp_i.rvalid) begin
      pending_q <= 1'b0;
    end
  end

  // Capture uses the old target when a new grant lands on the rvalid cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_a_o <= '0;
      rdata_b_o <= '0;
    end else if (rsp_i.rvalid) begin
      if (target_q) begin
        rdata_b_o <= rsp_i.rdata;
      end else begin
        rdata_a_o <= rsp_i.rdata;
      end
    end
  end

  a_rvalid_needs_read : assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_i.rvalid |-> pending_q);

  a_rvalid_after_gnt : assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_grant |=> rsp_i.rvalid);

endmodule

`default_nettype wire

//--- src/vrf_interface_top.sv
`timescale 1ns/1ps
`default_nettype none

module vrf_interface_top (
  input  logic               clk_i,
  input  logic               rst_ni,

  // Controller side
  input  logic               req_i,
  input  vrf_pkg::sel_op_t   sel_op_i,
  input  vrf_pkg::vtype_t    vtype_i,
  input  vrf_pkg::word_t     wdata_i,
  output logic               vector_done_o,

  // Register file bus
  output vrf_pkg::mem_req_t  mem_req_o,
  input  vrf_pkg::mem_rsp_t  mem_rsp_i,

  // Address generator and operands
  output vrf_pkg::agu_cmd_t  agu_o,
  output vrf_pkg::word_t     rdata_a_o,
  output vrf_pkg::word_t     rdata_b_o
);

  logic cnt_load;
  logic cnt_step;
  logic cnt_last;

  vrf_iter_counter u_iter_counter (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .load_i  (cnt_load),
    .step_i  (cnt_step),
    .vtype_i (vtype_i),
    .last_o  (cnt_last)
  );

  vrf_seq_ctrl u_seq_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .sel_op_i      (sel_op_i),
    .wdata_i       (wdata_i),
    .gnt_i         (mem_rsp_i.gnt),
    .last_i        (cnt_last),
    .load_o        (cnt_load),
    .step_o        (cnt_step),
    .mem_req_o     (mem_req_o),
    .agu_o         (agu_o),
    .vector_done_o (vector_done_o)
  );

  // Sees the same strobes the address generator gets
  vrf_operand_regs u_operand_regs (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .rsp_i     (mem_rsp_i),
    .agu_i     (agu_o),
    .rdata_a_o (rdata_a_o),
    .rdata_b_o (rdata_b_o)
  );

endmodule

`default_nettype wire

//--- include/tb_util.svh
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

//////////////////////////////////////////////////
// Random source
//////////////////////////////////////////////////

// Fibonacci LFSR with taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
  logic fb;
  fb = state[31] ^ state[21] ^ state[1] ^ state[0];
  return {state[30:0], fb};
endfunction

//////////////////////////////////////////////////
// Checking
//////////////////////////////////////////////////

task automatic check_eq(input string name, input logic [31:0] actual,
                        input logic [31:0] expected, ref int unsigned errors);
  if (actual !== expected) begin
    $display("CHECK FAILED at %0t: %s got %h expected %h",
             $time, name, actual, expected);
    errors++;
  end
endtask

`endif

//--- tests/tb_vrf_interface.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vrf_interface;

  `include "tb_util.svh"

  localparam int unsigned NUM_TESTS = 6;
  localparam int unsigned TIMEOUT   = 2000;

  typedef struct packed {
    vrf_pkg::sel_op_t sel;
    vrf_pkg::vsew_e   sew;
    vrf_pkg::vlmul_e  lmul;
    logic [7:0]       iters;
    vrf_pkg::word_t   wdata;
  } test_t;

  logic              clk_i;
  logic              rst_ni;
  logic              req_i;
  logic              done;
  vrf_pkg::sel_op_t  sel_op;
  vrf_pkg::vtype_t   vtype;
  vrf_pkg::word_t    wdata;
  vrf_pkg::mem_req_t mem_req;
  vrf_pkg::mem_rsp_t mem_rsp;
  vrf_pkg::agu_cmd_t agu;
  vrf_pkg::word_t    rdata_a;
  vrf_pkg::word_t    rdata_b;

  test_t          tests [NUM_TESTS];
  vrf_pkg::word_t mem [64];
  logic [5:0]     mem_addr;
  logic [5:0]     rd_addr;
  logic [31:0]    lfsr;
  logic           rd_issued;
  logic           rd_target;
  logic           chk_pending;
  logic           chk_target;
  vrf_pkg::word_t chk_data;
  int unsigned    errors;
  int unsigned    cnt_rs1;
  int unsigned    cnt_rs2;
  int unsigned    cnt_wr;
  int unsigned    cnt_grant;
  int unsigned    cnt_incr;
  int unsigned    cnt_load;
  int unsigned    cnt_done;
  int unsigned    tests_passed;
  int unsigned    tests_failed;
  int unsigned    xfer_kind;
  int             slot;
  int unsigned    exp_kinds [$];
  logic           timed_out;

  vrf_interface_top dut0 (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .sel_op_i      (sel_op),
    .vtype_i       (vtype),
    .wdata_i       (wdata),
    .vector_done_o (done),
    .mem_req_o     (mem_req),
    .mem_rsp_i     (mem_rsp),
    .agu_o         (agu),
    .rdata_a_o     (rdata_a),
    .rdata_b_o     (rdata_b)
  );

  always #50 clk_i = ~clk_i;

  //////////////////////////////////////////////////
  // Bus monitor sampled at the rising edge
  //////////////////////////////////////////////////

  always @(posedge clk_i) begin
    rd_issued = 1'b0;
    if (rst_ni) begin
      if (agu.incr) cnt_incr++;
      if (agu.load) cnt_load++;
      if (done) cnt_done++;
      if (mem_req.req && mem_rsp.gnt) begin
        cnt_grant++;
        if (mem_req.we) begin
          xfer_kind = 3;
          cnt_wr++;
          check_eq("dut0.mem_req_o.wdata", mem_req.wdata, wdata, errors);
          check_eq("dut0.agu_o.get_rd", 32'(agu.get_rd), 32'd1, errors);
          mem[mem_addr] = mem_req.wdata;
        end else begin
          xfer_kind = agu.get_rs1 ? 1 : (agu.get_rs2 ? 2 : 0);
          if (xfer_kind == 1) cnt_rs1++;
          if (xfer_kind == 2) cnt_rs2++;
          rd_issued = 1'b1;
          rd_target = (xfer_kind == 2);
          rd_addr   = mem_addr;
        end
        check_eq("transfer order", xfer_kind, exp_kinds[slot % exp_kinds.size()], errors);
        slot++;
        mem_addr = mem_addr + 6'd1;
      end
    end
  end

  // Memory model with random grants and rvalid one cycle after a read grant
  always @(negedge clk_i) begin
    if (chk_pending) begin
      if (chk_target) check_eq("dut0.rdata_b_o", rdata_b, chk_data, errors);
      else check_eq("dut0.rdata_a_o", rdata_a, chk_data, errors);
      chk_pending = 1'b0;
    end
    mem_rsp.rvalid = rd_issued;
    mem_rsp.rdata  = rd_issued ? mem[rd_addr] : '0;
    if (rd_issued) begin
      chk_pending = 1'b1;
      chk_target  = rd_target;
      chk_data    = mem[rd_addr];
    end
    if (mem_req.req) begin
      lfsr = lfsr_next(lfsr);
      mem_rsp.gnt = lfsr[0];
    end else begin
      mem_rsp.gnt = 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  // Iteration count is 16 elements / (SEW bytes) scaled by LMUL
  task automatic load_table();
    tests[0] = '{3'b111, vrf_pkg::SEW_32, vrf_pkg::LMUL_1,  8'd4,  32'hC0DE0001};
    tests[1] = '{3'b111, vrf_pkg::SEW_8,  vrf_pkg::LMUL_2,  8'd32, 32'h5EED0002};
    tests[2] = '{3'b111, vrf_pkg::SEW_16, vrf_pkg::LMUL_F2, 8'd4,  32'hABCD0003};
    tests[3] = '{3'b110, vrf_pkg::SEW_32, vrf_pkg::LMUL_2,  8'd8,  32'h0BAD0004};
    tests[4] = '{3'b011, vrf_pkg::SEW_64, vrf_pkg::LMUL_4,  8'd8,  32'h7E570005};
    tests[5] = '{3'b110, vrf_pkg::SEW_8,  vrf_pkg::LMUL_F8, 8'd2,  32'h1234ABCD};
  endtask

  task automatic run_test(input int unsigned idx);
    test_t       tc;
    int unsigned err_before;
    int unsigned cycles;
    tc         = tests[idx];
    err_before = errors;
    cnt_rs1    = 0;
    cnt_rs2    = 0;
    cnt_wr     = 0;
    cnt_grant  = 0;
    cnt_incr   = 0;
    cnt_load   = 0;
    cnt_done   = 0;
    slot = 0;
    exp_kinds.delete();
    if (tc.sel.rd_rs1) exp_kinds.push_back(1);
    exp_kinds.push_back(2);
    if (tc.sel.wr_rd) exp_kinds.push_back(3);
    sel_op     = tc.sel;
    vtype.sew  = tc.sew;
    vtype.lmul = tc.lmul;
    wdata      = tc.wdata;
    req_i      = 1'b1;
    @(negedge clk_i);
    req_i  = 1'b0;
    cycles = 0;
    while (cnt_done == 0 && cycles < TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (cnt_done == 0) begin
      $display("test %0d: vector_done_o never pulsed within %0d cycles", idx, TIMEOUT);
      timed_out = 1'b1;
      tests_failed++;
    end else begin
      repeat (2) @(negedge clk_i);
      check_eq("rs1 read count", cnt_rs1, tc.sel.rd_rs1 ? 32'(tc.iters) : 32'd0, errors);
      check_eq("rs2 read count", cnt_rs2, 32'(tc.iters), errors);
      check_eq("write count", cnt_wr, tc.sel.wr_rd ? 32'(tc.iters) : 32'd0, errors);
      check_eq("dut0.agu_o.incr count", cnt_incr, cnt_grant, errors);
      check_eq("dut0.agu_o.load count", cnt_load, 32'd1, errors);
      check_eq("dut0.vector_done_o count", cnt_done, 32'd1, errors);
      check_eq("dut0.mem_req_o.req", 32'(mem_req.req), 32'd0, errors);
      if (errors == err_before) tests_passed++;
      else tests_failed++;
      $display("test %0d: sel %b sew %0d lmul %0d, %0d iterations, %0d grants: %s",
               idx, tc.sel, tc.sew, tc.lmul, tc.iters, cnt_grant,
               (errors == err_before) ? "ok" : "FAILED");
    end
  endtask

  initial begin
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    req_i        = 1'b0;
    sel_op       = '0;
    vtype        = '0;
    wdata        = '0;
    mem_rsp      = '0;
    lfsr         = 32'h4713;
    errors       = 0;
    mem_addr     = '0;
    rd_addr      = '0;
    rd_issued    = 1'b0;
    rd_target    = 1'b0;
    chk_pending  = 1'b0;
    chk_target   = 1'b0;
    chk_data     = '0;
    tests_passed = 0;
    tests_failed = 0;
    timed_out    = 1'b0;
    for (int i = 0; i < 64; i++) begin
      mem[i] = (32'h9E3779B1 * 32'(i + 1)) ^ 32'h13572468;
    end
    load_table();
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_eq("dut0.mem_req_o.req", 32'(mem_req.req), 32'd0, errors);
    check_eq("dut0.mem_req_o.we", 32'(mem_req.we), 32'd0, errors);
    check_eq("dut0.agu_o", 32'(agu), 32'd0, errors);
    check_eq("dut0.vector_done_o", 32'(done), 32'd0, errors);
    check_eq("dut0.rdata_a_o", rdata_a, 32'd0, errors);
    check_eq("dut0.rdata_b_o", rdata_b, 32'd0, errors);
    $display("reset state: %s", (errors == 0) ? "ok" : "FAILED");
    for (int t = 0; t < NUM_TESTS && !timed_out; t++) begin
      run_test(t);
    end
    $display("Summary: %0d tests passed, %0d tests failed, %0d check errors",
             tests_passed, tests_failed, errors);
    if (errors == 0 && !timed_out) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
+incdir+include
src/vrf_pkg.sv
src/vrf_iter_counter.sv
src/vrf_seq_ctrl.sv
src/vrf_operand_regs.sv
src/vrf_interface_top.sv
tests/tb_vrf_interface.sv

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f list.f --top-module tb_vrf_interface

./obj_dir/Vtb_vrf_interface | tee "$LOG"

if grep -q "Testbench failed" "$LOG"; then
  exit 1
fi
exit 0
